//--- design/eth_pkg.sv
//****************************************************************************
// Ethernet transmit package
// shared types, frame constants, strobe structs and state enums
//****************************************************************************
package eth_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [1:0]  dibit_t;
	typedef logic [31:0] crc_t;

	// frame field lengths, in bytes
	localparam int ETH_MAC_LEN       = 6;
	localparam int ETH_ETHERTYPE_LEN = 2;
	localparam int ETH_PREAMBLE_LEN  = 8;
	localparam int ETH_CRC_LEN       = 4;
	localparam int ETH_GAP_LEN       = 12;

	// reflected polynomial, bits go out least significant first
	localparam crc_t CRC_INIT = 32'hffffffff;
	localparam crc_t CRC_POLY = 32'hedb88320;

	// address ROM layout
	localparam logic [3:0] MAC_DST_OFF = 4'd0;
	localparam logic [3:0] MAC_SRC_OFF = 4'd6;

	typedef struct packed {
		logic  valid;
		byte_t data;
		logic  last;
	} byte_strobe_t;

	typedef struct packed {
		logic   valid;
		dibit_t data;
	} dibit_strobe_t;

	typedef enum logic [2:0] {
		BODY_IDLE, BODY_MAC_DST, BODY_MAC_SRC, BODY_ETHERTYPE, BODY_PAYLOAD
	} body_state_t;

	typedef enum logic [2:0] {
		TX_IDLE, TX_PREAMBLE, TX_BODY, TX_CRC, TX_GAP
	} tx_state_t;

endpackage

//--- design/mac_addr_rom.sv
//****************************************************************************
// MAC address ROM
// twelve bytes, destination then source, with a registered read port
//****************************************************************************
`timescale 1ns/10ps

module mac_addr_rom #(
	parameter logic [47:0] MAC_DST = 48'h0,
	parameter logic [47:0] MAC_SRC = 48'h0
) (
	input  logic          clk,
	input  logic          rd,
	input  logic [3:0]    addr,
	output eth_pkg::byte_t data
);
	import eth_pkg::*;

	localparam int ROM_LEN = 2 * ETH_MAC_LEN;

	// wire order, first byte sits in the top octet
	localparam logic [8*ROM_LEN-1:0] ROM_BITS = {MAC_DST, MAC_SRC};

	always_ff @(posedge clk) begin
		if (rd) begin
			if (int'(addr) < ROM_LEN)
				data <= ROM_BITS[(ROM_LEN - 1 - int'(addr)) * 8 +: 8];
			else
				data <= '0;
		end
	end

endmodule

//--- design/eth_body_tx.sv
//****************************************************************************
// Ethernet body sequencer
// answers byte requests with header bytes, then payload until last
//****************************************************************************
`timescale 1ns/10ps

module eth_body_tx #(
	parameter logic [15:0] ETHERTYPE = 16'h0800
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  logic                 byte_req,
	output logic                 rom_rd,
	output logic [3:0]           rom_addr,
	input  eth_pkg::byte_t       rom_byte,
	input  eth_pkg::byte_strobe_t payload,
	output logic                 payload_req,
	output eth_pkg::byte_strobe_t body_byte
);
	import eth_pkg::*;

	localparam logic [2:0] MAC_LAST  = 3'(ETH_MAC_LEN - 1);
	localparam logic [2:0] TYPE_LAST = 3'(ETH_ETHERTYPE_LEN - 1);

	body_state_t state;
	logic [2:0]  cnt;
	byte_t       type_q;
	// which source answers on the next cycle
	logic        rom_pend, type_pend, pay_pend;
	logic        pay_in, last_in;

	assign rom_rd = byte_req && (state == BODY_MAC_DST || state == BODY_MAC_SRC);
	assign payload_req = byte_req && state == BODY_PAYLOAD;

	assign pay_in = pay_pend && payload.valid;
	assign last_in = pay_in && payload.last;

	assign body_byte = '{
		valid: rom_pend || type_pend || pay_in,
		data:  rom_pend ? rom_byte : (type_pend ? type_q : payload.data),
		last:  last_in
	};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= BODY_IDLE;
		end else if (start) begin
			state <= BODY_MAC_DST;
			cnt <= '0;
			rom_addr <= MAC_DST_OFF;
		end else if (byte_req) begin
			case (state)
				BODY_MAC_DST: begin
					cnt <= (cnt == MAC_LAST) ? 3'd0 : cnt + 3'd1;
					rom_addr <= (cnt == MAC_LAST) ? MAC_SRC_OFF : rom_addr + 4'd1;
					if (cnt == MAC_LAST)
						state <= BODY_MAC_SRC;
				end
				BODY_MAC_SRC: begin
					cnt <= (cnt == MAC_LAST) ? 3'd0 : cnt + 3'd1;
					rom_addr <= rom_addr + 4'd1;
					if (cnt == MAC_LAST)
						state <= BODY_ETHERTYPE;
				end
				BODY_ETHERTYPE: begin
					cnt <= cnt + 3'd1;
					if (cnt == TYPE_LAST)
						state <= BODY_PAYLOAD;
				end
				default: ;
			endcase
		end else if (state == BODY_PAYLOAD && last_in) begin
			state <= BODY_IDLE;
		end
	end

	// high byte first
	always_ff @(posedge clk) begin
		if (byte_req && state == BODY_ETHERTYPE)
			type_q <= (cnt == 3'd0) ? ETHERTYPE[15:8] : ETHERTYPE[7:0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rom_pend <= 1'b0;
			type_pend <= 1'b0;
			pay_pend <= 1'b0;
		end else begin
			rom_pend <= rom_rd;
			type_pend <= byte_req && state == BODY_ETHERTYPE;
			pay_pend <= payload_req;
		end
	end

endmodule

//--- design/byte_to_dibit.sv
//****************************************************************************
// Byte to dibit serializer
// gapless dibit stream, least significant dibit first, one byte ahead
//****************************************************************************
`timescale 1ns/10ps

module byte_to_dibit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  prefetch,
	output logic                  byte_req,
	input  eth_pkg::byte_strobe_t  in_byte,
	output eth_pkg::dibit_strobe_t dibit,
	output logic                  done
);
	import eth_pkg::*;

	byte_t      cur, nxt;
	logic       cur_last, nxt_last;
	logic       nxt_valid, active, load;
	logic [1:0] dcnt;

	// waiting byte moves in after the last dibit, or at once when idle
	assign load = nxt_valid && (!active || dcnt == 2'd3);

	// the answer lands in nxt just before the current byte runs out
	assign byte_req = prefetch || (active && dcnt == 2'd1 && !cur_last);
	assign done = active && dcnt == 2'd3 && cur_last;
	assign dibit = '{valid: active, data: cur[1:0]};

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			nxt_valid <= 1'b0;
			dcnt <= '0;
		end else begin
			if (in_byte.valid)
				nxt_valid <= 1'b1;
			else if (load)
				nxt_valid <= 1'b0;
			if (load) begin
				active <= 1'b1;
				dcnt <= '0;
			end else if (active) begin
				dcnt <= dcnt + 2'd1;
				if (dcnt == 2'd3)
					active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_byte.valid) begin
			nxt <= in_byte.data;
			nxt_last <= in_byte.last;
		end
		if (load) begin
			cur <= nxt;
			cur_last <= nxt_last;
		end else if (active) begin
			cur <= {2'b00, cur[7:2]};
		end
	end

endmodule

//--- design/crc32_dibit.sv
//****************************************************************************
// Dibit CRC-32
// reflected CRC folding two bits per cycle, doubles as shift register
//****************************************************************************
`timescale 1ns/10ps

module crc32_dibit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  init,
	input  logic                  shift,
	input  eth_pkg::dibit_strobe_t in,
	output eth_pkg::crc_t          crc
);
	import eth_pkg::*;

	crc_t step1, step2, step3;

	// xor both bits in, then two polynomial divisions
	assign step1 = {crc[31:2], crc[1:0] ^ in.data};
	assign step2 = {1'b0, step1[31:1]} ^ (step1[0] ? CRC_POLY : '0);
	assign step3 = {1'b0, step2[31:1]} ^ (step2[0] ? CRC_POLY : '0);

	always_ff @(posedge clk) begin
		if (rst || init)
			crc <= CRC_INIT;
		else if (shift)
			crc <= {2'b11, crc[31:2]};
		else if (in.valid)
			crc <= step3;
	end

endmodule

//--- design/eth_tx.sv
//****************************************************************************
// Ethernet frame transmitter
// preamble, serialized body, complemented CRC and interframe gap
//****************************************************************************
`timescale 1ns/10ps

module eth_tx #(
	parameter logic [15:0] ETHERTYPE = 16'h0800
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	output logic                  rom_rd,
	output logic [3:0]            rom_addr,
	input  eth_pkg::byte_t         rom_byte,
	input  eth_pkg::byte_strobe_t  payload,
	output logic                  payload_req,
	output eth_pkg::dibit_strobe_t tx,
	output logic                  busy,
	output logic                  done
);
	import eth_pkg::*;

	// counts are in dibits
	localparam logic [5:0] PRE_LAST    = 6'(ETH_PREAMBLE_LEN * 4 - 1);
	localparam logic [5:0] PREFETCH_AT = PRE_LAST - 6'd2;
	localparam logic [5:0] CRC_LAST    = 6'(ETH_CRC_LEN * 4 - 1);
	localparam logic [5:0] GAP_LAST    = 6'(ETH_GAP_LEN * 4 - 1);

	tx_state_t     state;
	logic [5:0]    cnt;
	logic          body_start, prefetch, sfd, body_done, byte_req;
	byte_strobe_t  body_byte;
	dibit_strobe_t body_dibit;
	crc_t          crc;

	assign body_start = start && state == TX_IDLE;
	assign sfd = state == TX_PREAMBLE && cnt == PRE_LAST;
	// early enough that the first body dibit follows the SFD
	assign prefetch = state == TX_PREAMBLE && cnt == PREFETCH_AT;
	assign busy = state != TX_IDLE;
	assign done = state == TX_GAP && cnt == GAP_LAST;

	eth_body_tx #(.ETHERTYPE(ETHERTYPE)) u_body (
		.clk(clk), .rst(rst), .start(body_start), .byte_req(byte_req),
		.rom_rd(rom_rd), .rom_addr(rom_addr), .rom_byte(rom_byte),
		.payload(payload), .payload_req(payload_req), .body_byte(body_byte)
	);

	byte_to_dibit u_ser (
		.clk(clk), .rst(rst), .prefetch(prefetch), .byte_req(byte_req),
		.in_byte(body_byte), .dibit(body_dibit), .done(body_done)
	);

	crc32_dibit u_crc (
		.clk(clk), .rst(rst), .init(sfd), .shift(state == TX_CRC),
		.in(body_dibit), .crc(crc)
	);

	always_comb begin
		case (state)
			TX_PREAMBLE: tx = '{valid: 1'b1, data: sfd ? 2'b11 : 2'b01};
			TX_BODY:     tx = body_dibit;
			TX_CRC:      tx = '{valid: 1'b1, data: ~crc[1:0]};
			default:     tx = '{valid: 1'b0, data: 2'b00};
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= TX_IDLE;
			cnt <= '0;
		end else begin
			cnt <= cnt + 6'd1;
			case (state)
				TX_IDLE: begin
					cnt <= '0;
					if (start)
						state <= TX_PREAMBLE;
				end
				TX_PREAMBLE:
					if (sfd)
						state <= TX_BODY;
				TX_BODY: begin
					cnt <= '0;
					if (body_done)
						state <= TX_CRC;
				end
				TX_CRC:
					if (cnt == CRC_LAST) begin
						state <= TX_GAP;
						cnt <= '0;
					end
				TX_GAP:
					if (done)
						state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

//--- design/eth_tx_top.sv
//****************************************************************************
// Ethernet transmit top level
// address ROM and frame transmitter
//****************************************************************************
`timescale 1ns/10ps

module eth_tx_top #(
	parameter logic [47:0] MAC_DST   = 48'hffffffffffff,
	parameter logic [47:0] MAC_SRC   = 48'h020000000001,
	parameter logic [15:0] ETHERTYPE = 16'h0800
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  eth_pkg::byte_strobe_t  payload,
	output logic                  payload_req,
	output eth_pkg::dibit_strobe_t tx,
	output logic                  busy,
	output logic                  done
);
	import eth_pkg::*;

	logic       rom_rd;
	logic [3:0] rom_addr;
	byte_t      rom_byte;

	mac_addr_rom #(.MAC_DST(MAC_DST), .MAC_SRC(MAC_SRC)) u_rom (
		.clk(clk), .rd(rom_rd), .addr(rom_addr), .data(rom_byte)
	);

	eth_tx #(.ETHERTYPE(ETHERTYPE)) u_eth_tx (
		.clk(clk), .rst(rst), .start(start),
		.rom_rd(rom_rd), .rom_addr(rom_addr), .rom_byte(rom_byte),
		.payload(payload), .payload_req(payload_req),
		.tx(tx), .busy(busy), .done(done)
	);

endmodule

//--- tb/tb_clock.sv
//****************************************************************************
// Testbench clock
// free-running clock, 40 ns period
//****************************************************************************
`timescale 1ns/10ps

module tb_clock #(
	parameter int PERIOD = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

//--- tb/eth_tx_asserts.sv
//****************************************************************************
// Frame transmitter assertions
// line continuity, byte request timing and done placement
//****************************************************************************
`timescale 1ns/10ps

module eth_tx_asserts (
	input logic                   clk,
	input logic                   rst,
	input eth_pkg::tx_state_t     state,
	input logic [5:0]             cnt,
	input logic                   byte_req,
	input eth_pkg::byte_strobe_t  body_byte,
	input eth_pkg::dibit_strobe_t tx,
	input logic                   done
);
	import eth_pkg::*;

	logic last_crc;
	int   fail_cnt = 0;

	// final dibit of the FCS
	assign last_crc = state == TX_CRC && cnt == 6'd15;

	valid_held: assert property (@(posedge clk) disable iff (rst)
		tx.valid && !last_crc |=> tx.valid)
		else begin
			$error("tx.valid dropped inside a frame");
			fail_cnt++;
		end

	no_req_outside_body: assert property (@(posedge clk) disable iff (rst)
		!(byte_req && (state == TX_IDLE || state == TX_GAP)))
		else begin
			$error("byte_req outside preamble and body");
			fail_cnt++;
		end

	// done closes a gap of 48 idle cycles after the last CRC dibit
	done_while_idle_line: assert property (@(posedge clk) disable iff (rst)
		done |-> !tx.valid && !$past(tx.valid, 47) && $past(tx.valid, 48))
		else begin
			$error("done not at the end of a 48-cycle idle gap");
			fail_cnt++;
		end

	byte_follows_req: assert property (@(posedge clk) disable iff (rst)
		byte_req |=> body_byte.valid)
		else begin
			$error("no body byte one cycle after byte_req");
			fail_cnt++;
		end

endmodule

bind eth_tx eth_tx_asserts u_asserts (
	.clk(clk), .rst(rst), .state(state), .cnt(cnt), .byte_req(byte_req),
	.body_byte(body_byte), .tx(tx), .done(done)
);

//--- tb/eth_tx_tb.sv
//****************************************************************************
// Ethernet transmitter testbench
// directed frames with a payload source model, frame capture and CRC model
//****************************************************************************
`timescale 1ns/10ps

module eth_tx_tb;
	import eth_pkg::*;

	localparam logic [47:0] MAC_DST   = 48'h02a1b2c3d4e5;
	localparam logic [47:0] MAC_SRC   = 48'h0a1122334455;
	localparam logic [15:0] ETHERTYPE = 16'h88b5;
	localparam int PRE_BYTES  = 8;
	localparam int HDR_BYTES  = 14;
	localparam int FCS_BYTES  = 4;
	localparam int GAP_CYCLES = 48;
	// eleven frames of at most 410 cycles and one cut short, plus margin
	localparam int TIMEOUT_CYCLES = 5000;

	logic          clk, rst, start, payload_req, busy, done;
	byte_strobe_t  payload;
	dibit_strobe_t tx;

	integer seed;
	int     errors = 0;
	int     checks = 0;
	int     cycles = 0;
	dibit_t dibit_q[$];
	byte_t  frame_bytes[$], exp_pay[$], exp_body[$], pay_q[$];
	int     valid_cnt, rise_cnt, gap_cnt, done_gap, done_cnt, req_cnt;
	logic   prev_valid, busy_after_done, req_seen;

	tb_clock #(.PERIOD(40)) u_clock (.clk(clk));

	eth_tx_top #(.MAC_DST(MAC_DST), .MAC_SRC(MAC_SRC), .ETHERTYPE(ETHERTYPE)) u_eth_tx_top (
		.clk(clk), .rst(rst), .start(start), .payload(payload), .payload_req(payload_req),
		.tx(tx), .busy(busy), .done(done)
	);

	// upstream source, answers one cycle after each request
	initial begin
		byte_t b;
		payload = '0;
		req_seen = 1'b0;
		forever begin
			@(negedge clk);
			if (req_seen && pay_q.size() > 0) begin
				b = pay_q.pop_front();
				payload.valid = 1'b1;
				payload.data = b;
				payload.last = (pay_q.size() == 0);
			end else begin
				if (req_seen && !rst) begin
					errors++;
					$display("payload source ran out of bytes at %0t", $time);
				end
				payload = '0;
			end
			req_seen = payload_req;
		end
	end

	// line capture, sampled mid-cycle
	initial begin
		prev_valid = 1'b0;
		forever begin
			@(negedge clk);
			if (tx.valid) begin
				dibit_q.push_back(tx.data);
				valid_cnt++;
				if (!prev_valid)
					rise_cnt++;
			end else if (busy && valid_cnt > 0) begin
				gap_cnt++;
			end
			if (done) begin
				done_cnt++;
				done_gap = gap_cnt;
			end
			if (payload_req)
				req_cnt++;
			prev_valid = tx.valid;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic compare_crc(input string name, input crc_t got, input crc_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %08h expected %08h", $time, name, got, exp);
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// bit-serial reflected CRC-32, each byte least significant bit first
	function automatic crc_t ref_crc(input byte_t data[$]);
		crc_t c;
		logic fb;
		c = 32'hffffffff;
		foreach (data[i]) begin
			for (int b = 0; b < 8; b++) begin
				fb = c[0] ^ data[i][b];
				c = {1'b0, c[31:1]};
				if (fb)
					c = c ^ 32'hedb88320;
			end
		end
		return c;
	endfunction

	task automatic make_payload(input int n);
		exp_pay.delete();
		for (int i = 0; i < n; i++)
			exp_pay.push_back(byte_t'($random(seed)));
	endtask

	task automatic clear_capture();
		dibit_q.delete();
		valid_cnt = 0;
		rise_cnt = 0;
		gap_cnt = 0;
		done_gap = 0;
		done_cnt = 0;
		req_cnt = 0;
	endtask

	// called on a falling edge with the DUT idle, returns one cycle after done
	task automatic send_frame(input int mid_start_at);
		int k;
		pay_q = exp_pay;
		clear_capture();
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		compare_count("tx.valid after start", int'(tx.valid), 1);
		compare_count("busy after start", int'(busy), 1);
		k = 1;
		while (!done) begin
			@(negedge clk);
			k++;
			start = (k == mid_start_at);
		end
		start = 1'b0;
		@(negedge clk);
		busy_after_done = busy;
	endtask

	task automatic check_frame(input int n);
		int   exp_cycles;
		int   base;
		crc_t fcs;
		exp_cycles = 4 * (PRE_BYTES + HDR_BYTES + n + FCS_BYTES);
		// header in wire order, most significant octet first
		exp_body.delete();
		for (int i = 0; i < 6; i++)
			exp_body.push_back(MAC_DST[47 - 8 * i -: 8]);
		for (int i = 0; i < 6; i++)
			exp_body.push_back(MAC_SRC[47 - 8 * i -: 8]);
		exp_body.push_back(ETHERTYPE[15:8]);
		exp_body.push_back(ETHERTYPE[7:0]);
		foreach (exp_pay[i])
			exp_body.push_back(exp_pay[i]);
		compare_count("tx.valid cycles", valid_cnt, exp_cycles);
		compare_count("tx.valid rising edges", rise_cnt, 1);
		compare_count("payload_req strobes", req_cnt, n);
		frame_bytes.delete();
		for (int i = 0; i + 3 < dibit_q.size(); i += 4)
			frame_bytes.push_back({dibit_q[i + 3], dibit_q[i + 2], dibit_q[i + 1], dibit_q[i]});
		if (valid_cnt == exp_cycles) begin
			// 31 dibits of 01 then 11 give seven 55 bytes and d5
			for (int i = 0; i < PRE_BYTES; i++)
				compare_byte($sformatf("preamble byte %0d", i), frame_bytes[i],
					(i == PRE_BYTES - 1) ? 8'hd5 : 8'h55);
			for (int i = 0; i < n; i++)
				compare_byte($sformatf("payload byte %0d", i),
					frame_bytes[PRE_BYTES + HDR_BYTES + i], exp_pay[i]);
			base = PRE_BYTES + HDR_BYTES + n;
			fcs = {frame_bytes[base + 3], frame_bytes[base + 2],
				frame_bytes[base + 1], frame_bytes[base]};
			compare_crc("fcs", fcs, ~ref_crc(exp_body));
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - err_before);
	endtask

	task automatic test_one_byte();
		int e0;
		e0 = errors;
		exp_pay.delete();
		exp_pay.push_back(8'h5a);
		send_frame(0);
		check_frame(1);
		report_test("test 1 one-byte payload", e0);
	endtask

	task automatic test_header();
		int e0;
		e0 = errors;
		make_payload(2);
		send_frame(0);
		check_frame(2);
		if (frame_bytes.size() >= PRE_BYTES + HDR_BYTES) begin
			for (int i = 0; i < HDR_BYTES; i++)
				compare_byte($sformatf("header byte %0d", i), frame_bytes[PRE_BYTES + i],
					exp_body[i]);
		end else begin
			errors++;
			$display("frame too short to hold the header");
		end
		report_test("test 2 header content", e0);
	endtask

	task automatic test_random_payloads();
		int e0;
		int n;
		e0 = errors;
		for (int f = 0; f < 5; f++) begin
			n = 1 + int'($unsigned($random(seed)) % 64);
			make_payload(n);
			send_frame(0);
			check_frame(n);
		end
		report_test("test 3 random payloads", e0);
	endtask

	task automatic test_gap_done();
		int e0;
		e0 = errors;
		make_payload(3);
		send_frame(0);
		check_frame(3);
		compare_count("gap cycles up to done", done_gap, GAP_CYCLES);
		compare_count("done strobes", done_cnt, 1);
		compare_count("busy after done", int'(busy_after_done), 0);
		report_test("test 4 gap and done", e0);
	endtask

	task automatic test_start_while_busy();
		int e0;
		e0 = errors;
		make_payload(4);
		// second start lands inside the header bytes
		send_frame(40);
		check_frame(4);
		make_payload(3);
		send_frame(0);
		check_frame(3);
		report_test("test 5 start while busy", e0);
	endtask

	task automatic test_reset_mid_frame();
		int e0;
		e0 = errors;
		make_payload(20);
		pay_q = exp_pay;
		clear_capture();
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		repeat (60) @(negedge clk);
		rst = 1'b1;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		pay_q.delete();
		compare_count("tx.valid after reset", int'(tx.valid), 0);
		compare_count("busy after reset", int'(busy), 0);
		compare_count("payload_req after reset", int'(payload_req), 0);
		@(negedge clk);
		make_payload(5);
		send_frame(0);
		check_frame(5);
		report_test("test 6 reset mid-frame", e0);
	endtask

	initial begin
		seed = 32'h7af2;
		rst = 1'b1;
		start = 1'b0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		test_one_byte();
		test_header();
		test_random_payloads();
		test_gap_done();
		test_start_while_busy();
		test_reset_mid_frame();
		// protocol assertion failures count as errors too
		errors += u_eth_tx_top.u_eth_tx.u_asserts.fail_cnt;
		$display("6 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- eth_tx_sub.f
design/eth_pkg.sv
design/mac_addr_rom.sv
design/eth_body_tx.sv
design/byte_to_dibit.sv
design/crc32_dibit.sv
design/eth_tx.sv
design/eth_tx_top.sv
tb/tb_clock.sv
tb/eth_tx_asserts.sv
tb/eth_tx_tb.sv

//--- Makefile
TOOL      = verilator
TOP       = eth_tx_tb
FILELIST  = eth_tx_sub.f
FLAGS     = --timing --assert
SIM_FLAGS = $(FLAGS) --binary -j 0
LINT_FLAGS = $(FLAGS) --lint-only
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Regression failed

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
